//--- uart_lite.f
uart_lite_pkg.sv
uart_apb_pkg.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_apb_regs.sv
uart_lite_top.sv
uart_lite_sva.sv
tb_uart_lite.sv

//--- Bender.yml
package:
  name: uart_lite

sources:
  # Design, packages first
  - files:
      - uart_lite_pkg.sv
      - uart_apb_pkg.sv
      - uart_baud_gen.sv
      - uart_tx.sv
      - uart_rx.sv
      - uart_apb_regs.sv
      - uart_lite_top.sv
  # Testbench and bound assertions
  - target: test
    files:
      - uart_lite_sva.sv
      - tb_uart_lite.sv

//--- tb_uart_lite.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven UART testbench with APB driver,
// loopback and serial frame injection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_uart_lite
  import uart_lite_pkg::*;
  import uart_apb_pkg::*;
();

  localparam int TAB_SIZE    = 64;
  localparam int APB_TIMEOUT = 16;
  localparam int POLL_LIMIT  = 300;

  // Table operations
  localparam logic [2:0] OP_WR   = 3'd0;
  localparam logic [2:0] OP_RD   = 3'd1;
  localparam logic [2:0] OP_POLL = 3'd2;
  localparam logic [2:0] OP_MODE = 3'd3;
  localparam logic [2:0] OP_INJ  = 3'd4;

  // Expected STATUS bits
  localparam apb_data_t ST_BUSY  = apb_data_t'(1) << STAT_TX_BUSY;
  localparam apb_data_t ST_VALID = apb_data_t'(1) << STAT_RX_VALID;
  localparam apb_data_t ST_OVR   = apb_data_t'(1) << STAT_OVERRUN;
  localparam apb_data_t ST_FERR  = apb_data_t'(1) << STAT_FRAME_ERR;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  logic        rxd;
  logic        txd;
  // rxd source: txd in loopback, else the frame driver
  logic        loopback;
  logic        drv_rxd;
  // Bit length the frame driver uses
  uart_div_t   cur_div;
  int unsigned seed;

  // Stimulus table
  logic [2:0]  tab_op   [0:TAB_SIZE-1];
  apb_addr_t   tab_addr [0:TAB_SIZE-1];
  apb_data_t   tab_data [0:TAB_SIZE-1];
  apb_data_t   tab_exp  [0:TAB_SIZE-1];
  logic        tab_err  [0:TAB_SIZE-1];
  int          tab_len;

  assign rxd = loopback ? txd : drv_rxd;

  uart_lite_top dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rxd     (rxd),
    .txd     (txd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input apb_data_t actual, input apb_data_t expected);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s = 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      report_failure();
    end
  endtask

  // One APB transfer, setup then access, sampled mid-cycle
  task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    int n;
    n = 0;
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      if (n >= APB_TIMEOUT) begin
        $display("timeout: pready never rose for access to 0x%0h", addr);
        report_failure();
      end
      n++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Read STATUS until the masked bits match
  task automatic poll_status(input apb_data_t mask, input apb_data_t expected);
    apb_data_t st;
    logic      err;
    int        n;
    logic      hit;
    n   = 0;
    hit = 1'b0;
    while (!hit) begin
      if (n >= POLL_LIMIT) begin
        $display("timeout: STATUS never showed 0x%0h under mask 0x%0h", expected, mask);
        report_failure();
      end
      apb_xfer(1'b0, REG_STATUS, '0, st, err);
      check("pslverr", apb_data_t'(err), '0);
      hit = ((st & mask) == expected);
      n++;
    end
  endtask

  // Serial frame on rxd: start 0, data LSB first, chosen stop bit
  task automatic send_frame(input uart_byte_t data, input logic stop);
    logic [UART_FRAME_BITS-1:0] bits;
    int                         k;
    bits = {stop, data, 1'b0};
    @(posedge clk);
    #2;
    for (k = 0; k < UART_FRAME_BITS; k++) begin
      drv_rxd = bits[k];
      repeat (cur_div) @(posedge clk);
      #2;
    end
    drv_rxd = 1'b1;
  endtask

  task automatic add_step(input logic [2:0] op, input apb_addr_t addr, input apb_data_t data,
                          input apb_data_t expected, input logic err);
    tab_op[tab_len]   = op;
    tab_addr[tab_len] = addr;
    tab_data[tab_len] = data;
    tab_exp[tab_len]  = expected;
    tab_err[tab_len]  = err;
    tab_len++;
  endtask

  // Send a byte, wait for it back with tx idle, read and clear it
  task automatic add_loop_frame(input uart_byte_t b);
    add_step(OP_WR, REG_DATA, apb_data_t'(b), '0, 1'b0);
    add_step(OP_POLL, REG_STATUS, ST_BUSY | ST_VALID, ST_VALID, 1'b0);
    add_step(OP_RD, REG_DATA, '0, apb_data_t'(b), 1'b0);
    add_step(OP_RD, REG_STATUS, '0, '0, 1'b0);
  endtask

  task automatic build_table();
    uart_byte_t a;
    uart_byte_t b;
    int         k;
    tab_len = 0;
    // Reset values
    add_step(OP_RD, REG_STATUS, '0, '0, 1'b0);
    add_step(OP_RD, REG_DIV, '0, 32'd16, 1'b0);
    // DIV read back, then loopback at 16 and 5 clocks per bit
    add_step(OP_WR, REG_DIV, 32'h00a7, '0, 1'b0);
    add_step(OP_RD, REG_DIV, '0, 32'h00a7, 1'b0);
    add_step(OP_WR, REG_DIV, 32'd16, '0, 1'b0);
    add_step(OP_MODE, '0, 32'd1, '0, 1'b0);
    for (k = 0; k < 2; k++)
      add_loop_frame(uart_byte_t'($urandom));
    add_step(OP_WR, REG_DIV, 32'd5, '0, 1'b0);
    add_step(OP_RD, REG_DIV, '0, 32'd5, 1'b0);
    for (k = 0; k < 2; k++)
      add_loop_frame(uart_byte_t'($urandom));
    // Second DATA write lands while busy and is dropped
    a = uart_byte_t'($urandom);
    b = ~a;
    add_step(OP_WR, REG_DATA, apb_data_t'(a), '0, 1'b0);
    add_step(OP_RD, REG_STATUS, '0, ST_BUSY, 1'b0);
    add_step(OP_WR, REG_DATA, apb_data_t'(b), '0, 1'b0);
    add_step(OP_POLL, REG_STATUS, ST_BUSY | ST_VALID, ST_VALID, 1'b0);
    add_step(OP_RD, REG_DATA, '0, apb_data_t'(a), 1'b0);
    add_step(OP_RD, REG_STATUS, '0, '0, 1'b0);
    // Two frames with no DATA read in between
    a = uart_byte_t'($urandom);
    b = ~a;
    add_step(OP_WR, REG_DATA, apb_data_t'(a), '0, 1'b0);
    add_step(OP_POLL, REG_STATUS, ST_BUSY | ST_VALID, ST_VALID, 1'b0);
    add_step(OP_WR, REG_DATA, apb_data_t'(b), '0, 1'b0);
    // This STATUS read also clears overrun
    add_step(OP_POLL, REG_STATUS, ST_OVR, ST_OVR, 1'b0);
    add_step(OP_RD, REG_DATA, '0, apb_data_t'(b), 1'b0);
    add_step(OP_POLL, REG_STATUS, ST_BUSY, '0, 1'b0);
    add_step(OP_RD, REG_STATUS, '0, '0, 1'b0);
    // Injected frames, good stop then bad stop
    a = uart_byte_t'($urandom);
    b = uart_byte_t'($urandom);
    add_step(OP_MODE, '0, 32'd0, '0, 1'b0);
    add_step(OP_INJ, '0, {23'd0, 1'b1, a}, '0, 1'b0);
    add_step(OP_POLL, REG_STATUS, ST_VALID, ST_VALID, 1'b0);
    add_step(OP_RD, REG_STATUS, '0, ST_VALID, 1'b0);
    add_step(OP_RD, REG_DATA, '0, apb_data_t'(a), 1'b0);
    add_step(OP_INJ, '0, {23'd0, 1'b0, b}, '0, 1'b0);
    add_step(OP_POLL, REG_STATUS, ST_FERR, ST_FERR, 1'b0);
    add_step(OP_RD, REG_DATA, '0, apb_data_t'(b), 1'b0);
    add_step(OP_RD, REG_STATUS, '0, '0, 1'b0);
    // Bus errors
    add_step(OP_RD, 8'h0c, '0, '0, 1'b1);
    add_step(OP_WR, 8'h0c, 32'h5a, '0, 1'b1);
    add_step(OP_WR, REG_STATUS, 32'hf, '0, 1'b1);
    add_step(OP_RD, REG_STATUS, '0, '0, 1'b0);
    add_step(OP_RD, REG_DIV, '0, 32'd5, 1'b0);
  endtask

  initial begin
    int          i;
    apb_data_t   rdata;
    logic        slverr;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    arst_n   = 1'b0;
    loopback = 1'b0;
    drv_rxd  = 1'b1;
    cur_div  = 16'd16;
    seed     = 32'hc8a7;
    void'($urandom(seed));
    build_table();
    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;
    for (i = 0; i < tab_len; i++) begin
      case (tab_op[i])
        OP_WR: begin
          apb_xfer(1'b1, tab_addr[i], tab_data[i], rdata, slverr);
          check("pslverr", apb_data_t'(slverr), apb_data_t'(tab_err[i]));
          // Frame driver follows the bit length
          if ((tab_addr[i] == REG_DIV) && !slverr)
            cur_div = tab_data[i][15:0];
        end
        OP_RD: begin
          apb_xfer(1'b0, tab_addr[i], '0, rdata, slverr);
          check("prdata", rdata, tab_exp[i]);
          check("pslverr", apb_data_t'(slverr), apb_data_t'(tab_err[i]));
        end
        OP_POLL: poll_status(tab_data[i], tab_exp[i]);
        OP_MODE: begin
          @(posedge clk);
          #2;
          loopback = tab_data[i][0];
        end
        OP_INJ: send_frame(tab_data[i][7:0], tab_data[i][8]);
        default: begin
          $display("bad table operation %0d at step %0d", tab_op[i], i);
          report_failure();
        end
      endcase
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- uart_lite_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transmit frame assertions, bound to uart_tx
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_lite_sva
  import uart_lite_pkg::*;
(
  input logic clk,
  input logic arst_n,
  input logic tx_start,
  input logic tx_tick,
  input logic txd,
  input logic tx_busy
);

  // Bit ticks seen since the frame started
  logic [3:0] tick_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= '0;
    end else if (tx_start && !tx_busy) begin
      tick_cnt <= '0;
    end else if (tx_busy && tx_tick) begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // Line idles high between frames
  idle_high: assert property (@(posedge clk) disable iff (!arst_n)
    !tx_busy |-> txd)
    else $error("txd low while transmitter idle");

  // Start bit still on the line at the first bit boundary
  start_low: assert property (@(posedge clk) disable iff (!arst_n)
    (tx_busy && tx_tick && (tick_cnt == 4'd0)) |-> !txd)
    else $error("txd not low at first tick of frame");

  // Frame ends only after all ten slots
  full_frame: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(tx_busy) |-> (tick_cnt == 4'(UART_FRAME_BITS)))
    else $error("tx_busy fell after %0d ticks", tick_cnt);

endmodule

bind uart_tx uart_lite_sva u_sva (
  .clk      (clk),
  .arst_n   (arst_n),
  .tx_start (tx_start),
  .tx_tick  (tx_tick),
  .txd      (txd),
  .tx_busy  (tx_busy)
);

//--- uart_lite_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB UART top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_lite_top
  import uart_lite_pkg::*;
  import uart_apb_pkg::*;
#(
  parameter uart_div_t DIV_RESET = 16
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  input  logic      rxd,
  output logic      txd
);

  // Transmit path
  logic       tx_start;
  uart_byte_t tx_data;
  logic       tx_busy;
  logic       tx_tick;
  // Receive path
  logic       rx_sample;
  logic       rx_resync;
  logic       rx_busy;
  uart_byte_t rx_data;
  logic       rx_done;
  logic       rx_err;
  uart_div_t  div;

  uart_apb_regs #(
    .DIV_RESET (DIV_RESET)
  ) u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .tx_busy  (tx_busy),
    .rx_done  (rx_done),
    .rx_err   (rx_err),
    .rx_data  (rx_data),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .div      (div)
  );

  uart_baud_gen u_baud (
    .clk       (clk),
    .arst_n    (arst_n),
    .div       (div),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .rx_resync (rx_resync),
    .rx_busy   (rx_busy),
    .tx_tick   (tx_tick),
    .rx_sample (rx_sample)
  );

  uart_tx u_tx (
    .clk      (clk),
    .arst_n   (arst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_tick  (tx_tick),
    .txd      (txd),
    .tx_busy  (tx_busy)
  );

  uart_rx u_rx (
    .clk       (clk),
    .arst_n    (arst_n),
    .rxd       (rxd),
    .rx_sample (rx_sample),
    .rx_resync (rx_resync),
    .rx_busy   (rx_busy),
    .rx_data   (rx_data),
    .rx_done   (rx_done),
    .rx_err    (rx_err)
  );

endmodule

//--- uart_apb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register block: DATA, STATUS, DIV
// and datapath control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_apb_regs
  import uart_lite_pkg::*;
  import uart_apb_pkg::*;
#(
  parameter uart_div_t DIV_RESET = 16
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_addr_t  paddr,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pready,
  output logic       pslverr,
  input  logic       tx_busy,
  input  logic       rx_done,
  input  logic       rx_err,
  input  uart_byte_t rx_data,
  output logic       tx_start,
  output uart_byte_t tx_data,
  output uart_div_t  div
);

  // Access phase strobes
  logic       access;
  logic       wr_en;
  logic       rd_en;
  logic       addr_hit;
  logic       data_rd;
  logic       stat_rd;
  logic       div_wr;

  uart_div_t  div_q;
  uart_byte_t rx_byte_q;
  logic       rx_valid_q;
  logic       overrun_q;
  logic       frame_err_q;
  apb_data_t  status_word;

  assign access   = psel && penable;
  assign wr_en    = access && pwrite;
  assign rd_en    = access && !pwrite;
  assign addr_hit = (paddr == REG_DATA) || (paddr == REG_STATUS) || (paddr == REG_DIV);
  assign data_rd  = rd_en && (paddr == REG_DATA);
  assign stat_rd  = rd_en && (paddr == REG_STATUS);
  assign div_wr   = wr_en && (paddr == REG_DIV);

  // No wait states
  assign pready  = 1'b1;
  // STATUS is read-only
  assign pslverr = access && (!addr_hit || (pwrite && (paddr == REG_STATUS)));

  // Byte goes straight to the shifter, dropped while a frame is running
  assign tx_start = wr_en && (paddr == REG_DATA) && !tx_busy;
  assign tx_data  = pwdata[7:0];
  assign div      = div_q;

  always_comb begin
    status_word                 = '0;
    status_word[STAT_TX_BUSY]   = tx_busy;
    status_word[STAT_RX_VALID]  = rx_valid_q;
    status_word[STAT_OVERRUN]   = overrun_q;
    status_word[STAT_FRAME_ERR] = frame_err_q;
  end

  // Read mux, valid in the access cycle
  always_comb begin
    case (paddr)
      REG_DATA:   prdata = apb_data_t'(rx_byte_q);
      REG_STATUS: prdata = status_word;
      REG_DIV:    prdata = apb_data_t'(div_q);
      default:    prdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_q       <= DIV_RESET;
      rx_valid_q  <= 1'b0;
      overrun_q   <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      if (div_wr)
        div_q <= pwdata[15:0];
      // New byte wins over a same-cycle DATA read
      if (rx_done)
        rx_valid_q <= 1'b1;
      else if (data_rd)
        rx_valid_q <= 1'b0;
      // Unread byte about to be overwritten
      if (rx_done && rx_valid_q && !data_rd)
        overrun_q <= 1'b1;
      else if (stat_rd)
        overrun_q <= 1'b0;
      if (rx_done && rx_err)
        frame_err_q <= 1'b1;
      else if (stat_rd)
        frame_err_q <= 1'b0;
    end
  end

  // Last received byte, overwritten on overrun
  always_ff @(posedge clk) begin
    if (rx_done)
      rx_byte_q <= rx_data;
  end

endmodule

//--- uart_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receiver FSM with start detection,
// mid-bit sampling and stop-bit check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_rx
  import uart_lite_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rxd,
  input  logic       rx_sample,
  output logic       rx_resync,
  output logic       rx_busy,
  output uart_byte_t rx_data,
  output logic       rx_done,
  output logic       rx_err
);

  rx_state_t  state_q;
  // Two-flop synchronizer plus one stage for edge detect
  logic       rxd_meta;
  logic       rxd_sync;
  logic       rxd_prev;
  logic       fall;
  logic [2:0] bit_q;
  uart_byte_t shift_q;
  logic       shift_en;

  assign fall      = rxd_prev && !rxd_sync;
  // Restart the sample counter on the start edge
  assign rx_resync = (state_q == RX_IDLE) && fall;
  assign rx_busy   = (state_q != RX_IDLE);
  assign shift_en  = (state_q == RX_DATA) && rx_sample;
  assign rx_data   = shift_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
      state_q  <= RX_IDLE;
      bit_q    <= '0;
      rx_done  <= 1'b0;
      rx_err   <= 1'b0;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
      // Single-cycle pulse
      rx_done  <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (fall)
            state_q <= RX_START;
        end
        RX_START: begin
          if (rx_sample) begin
            // Start bit gone high by mid-bit is a glitch
            if (rxd_sync == UART_START_BIT) begin
              bit_q   <= '0;
              state_q <= RX_DATA;
            end else begin
              state_q <= RX_IDLE;
            end
          end
        end
        RX_DATA: begin
          if (rx_sample) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'(UART_DATA_BITS - 1))
              state_q <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (rx_sample) begin
            rx_done <= 1'b1;
            rx_err  <= (rxd_sync != UART_STOP_BIT);
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data shifts in LSB first
  always_ff @(posedge clk) begin
    if (shift_en)
      shift_q <= {rxd_sync, shift_q[UART_DATA_BITS-1:1]};
  end

endmodule

//--- uart_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmit shifter, one frame per byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_tx
  import uart_lite_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       tx_start,
  input  uart_byte_t tx_data,
  input  logic       tx_tick,
  output logic       txd,
  output logic       tx_busy
);

  tx_state_t                  state_q;
  // Bit 0 is always the bit on the line
  logic [UART_FRAME_BITS-1:0] frame_q;
  // Slot index inside the frame
  logic [3:0]                 slot_q;
  logic                       last_slot;

  assign last_slot = (slot_q == 4'(UART_FRAME_BITS - 1));
  assign tx_busy   = (state_q == TX_SHIFT);
  assign txd       = frame_q[0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= TX_IDLE;
      // All ones keeps the line idle high
      frame_q <= '1;
      slot_q  <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (tx_start) begin
            frame_q <= {UART_STOP_BIT, tx_data, UART_START_BIT};
            slot_q  <= '0;
            state_q <= TX_SHIFT;
          end
        end
        TX_SHIFT: begin
          if (tx_tick) begin
            // Shift in idle level behind the stop bit
            frame_q <= {UART_STOP_BIT, frame_q[UART_FRAME_BITS-1:1]};
            slot_q  <= slot_q + 1'b1;
            // End of stop bit
            if (last_slot)
              state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

//--- uart_baud_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit-rate generator: tx bit tick and
// rx mid-bit sample strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_baud_gen
  import uart_lite_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  uart_div_t div,
  input  logic      tx_start,
  input  logic      tx_busy,
  input  logic      rx_resync,
  input  logic      rx_busy,
  output logic      tx_tick,
  output logic      rx_sample
);

  // Divisor copies frozen per frame
  uart_div_t tx_div_q;
  uart_div_t rx_div_q;
  // Down-counters to the next strobe
  uart_div_t tx_cnt_q;
  uart_div_t rx_cnt_q;

  // Strobe on terminal count while the side is active
  assign tx_tick   = tx_busy && (tx_cnt_q == '0);
  assign rx_sample = rx_busy && (rx_cnt_q == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_div_q <= '0;
      rx_div_q <= '0;
      tx_cnt_q <= '0;
      rx_cnt_q <= '0;
    end else begin
      // Transmit side restarts on every accepted byte
      if (tx_start) begin
        tx_div_q <= div;
        tx_cnt_q <= div - 1'b1;
      end else if (tx_busy) begin
        if (tx_cnt_q == '0)
          tx_cnt_q <= tx_div_q - 1'b1;
        else
          tx_cnt_q <= tx_cnt_q - 1'b1;
      end
      // Receive side first waits half a bit so samples land mid-bit
      if (rx_resync) begin
        rx_div_q <= div;
        rx_cnt_q <= (div >> 1) - 1'b1;
      end else if (rx_busy) begin
        if (rx_cnt_q == '0)
          rx_cnt_q <= rx_div_q - 1'b1;
        else
          rx_cnt_q <= rx_cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- uart_apb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB-side types, register map and
// status bit positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_apb_pkg;

  // Bus widths
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Register offsets
  localparam apb_addr_t REG_DATA   = 8'h00;
  localparam apb_addr_t REG_STATUS = 8'h04;
  localparam apb_addr_t REG_DIV    = 8'h08;

  // STATUS bit positions
  localparam int STAT_TX_BUSY   = 0;
  localparam int STAT_RX_VALID  = 1;
  localparam int STAT_OVERRUN   = 2;
  // Stop bit sampled as 0
  localparam int STAT_FRAME_ERR = 3;

endpackage

//--- uart_lite_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial-side UART types, frame constants
// and state machine encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_lite_pkg;

  // One data byte on the line
  typedef logic [7:0] uart_byte_t;

  // Clocks per bit
  typedef logic [15:0] uart_div_t;

  // Frame layout: start, 8 data LSB first, stop
  localparam int   UART_DATA_BITS  = 8;
  localparam int   UART_FRAME_BITS = 10;
  localparam logic UART_START_BIT  = 1'b0;
  localparam logic UART_STOP_BIT   = 1'b1;

  // Receiver FSM
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  // Transmitter FSM
  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;

endpackage
